//--- files.f
+incdir+include
src/displayPkg.sv
src/monitorPkg.sv
src/monitorInput.sv
src/screenComposer.sv
src/charStreamer.sv
src/lcdMonitorTop.sv
sim/lcdMonitor_chk.sv
sim/tbLcdMonitor.sv

//--- include/screenText.svh
`ifndef SCREEN_TEXT_SVH
`define SCREEN_TEXT_SVH

// fixed text of the set-up dialog, one 16 character string per line
function automatic displayPkg::charCodeT screenChar(
	input monitorPkg::screenT screen,
	input displayPkg::lineIdxT line,
	input displayPkg::colIdxT col
);
	logic [8*displayPkg::ColumnCount-1:0] top;
	logic [8*displayPkg::ColumnCount-1:0] bottom;
	logic [8*displayPkg::ColumnCount-1:0] row;

	top = "                "; // blank unless a screen fills it
	bottom = "                ";
	case (screen)
		monitorPkg::startScreen:
		begin
			top = "Start Config    ";
			bottom = "Press Any Key   ";
		end
		monitorPkg::selectMaster:
		begin
			top = "Select Master   ";
		end
		monitorPkg::selectSlave:
		begin
			top = "Select Slave    ";
		end
		monitorPkg::inputAddress:
		begin
			top = "Input Address   ";
			bottom = "SW[0:11]        ";
		end
		monitorPkg::inputData:
		begin
			top = "Input Data      ";
			bottom = "SW[0:7]         ";
		end
		monitorPkg::inputBursts:
		begin
			top = "Input Number of ";
			bottom = "Bursts          ";
		end
		monitorPkg::saveConfig:
		begin
			top = "Save Config     ";
		end
		monitorPkg::doneScreen:
		begin
			top = "Config Done     ";
			bottom = "Start New Config";
		end
		default:
		begin
			top = "                "; // monitor screen is drawn elsewhere
		end
	endcase

	row = (line == 1'b1) ? bottom : top;
	// leftmost character sits in the top byte of the literal
	return row[8*(displayPkg::ColumnCount-1-col) +: 8];
endfunction

`endif

//--- sim/lcdMonitor_chk.sv
module lcdMonitor_chk (
	input logic m1_start,
	input logic m2_start,
	input monitorPkg::configStateT configState,
	input logic modeSwitch,
	input logic bus1Start,
	input logic bus2Start,
	input monitorPkg::busWordT bus1,
	input monitorPkg::busWordT bus2,
	input logic charReq,
	input logic charAck,
	input displayPkg::lcdCharT charOut
);

	`undef SCREEN_TEXT_SVH // the composer has normally pulled the table in already
	`include "screenText.svh"

	int errorCount = 0; // watched by the testbench
	logic refDone;
	logic reqPrev;
	logic reqRise;
	displayPkg::charPosT lastPos; // last accepted position
	displayPkg::charPosT expPos;
	monitorPkg::frameStateT refFrame [3]; // modelled screen and word, then two cycles of delay
	monitorPkg::frameStateT snap;
	monitorPkg::frameStateT curFrame;

	function automatic void noteFailure(input string msg);
		$error("%s", msg);
		errorCount++;
	endfunction

	function automatic displayPkg::charCodeT expectedCode(input monitorPkg::frameStateT f,
			input displayPkg::charPosT p);
		logic [monitorPkg::WordWidth-1:0] word;
		word = p.line ? f.captured.data : f.captured.address;
		if (f.screen != monitorPkg::monitorScreen)
			return screenChar(f.screen, p.line, p.col);
		else if (p.col == 4'd0)
			return p.line ? monitorPkg::DataTag : monitorPkg::AddressTag;
		else if (p.col == 4'd1)
			return displayPkg::CodeDash;
		return word[15 - p.col] ? displayPkg::CodeOne : displayPkg::CodeZero; // col 2 is bit 13
	endfunction

	always_ff @(posedge m1_start or posedge m2_start)
	begin
		if (m2_start)
		begin
			refDone <= 1'b0;
			refFrame <= '{default: '0}; // startScreen, empty words
			snap <= '0;
			reqPrev <= 1'b0;
			lastPos <= '1; // first expected position is line 0 col 0
		end
		else
		begin
			refDone <= !modeSwitch && (refDone || configState == monitorPkg::cfgSave);
			if (modeSwitch)
				refFrame[0].screen <= monitorPkg::monitorScreen;
			else if (configState == monitorPkg::cfgIdle)
				refFrame[0].screen <= refDone ? monitorPkg::doneScreen : monitorPkg::startScreen;
			else
				refFrame[0].screen <= monitorPkg::screenT'(configState); // steps 1 to 6 in order
			if (bus1Start)
				refFrame[0].captured <= bus1; // master 1 wins a tie
			else if (bus2Start)
				refFrame[0].captured <= bus2;
			refFrame[1] <= refFrame[0];
			refFrame[2] <= refFrame[1];
			reqPrev <= charReq;
			snap <= curFrame;
			if (charReq && charAck)
				lastPos <= charOut.pos;
		end
	end

	assign reqRise = charReq && !reqPrev;
	// a new frame takes what the inputs showed two cycles before its first request
	assign curFrame = (reqRise && charOut.pos == '0) ? refFrame[2] : snap;
	assign expPos = (lastPos.col == 4'd15) ? {~lastPos.line, 4'd0}
		: {lastPos.line, lastPos.col + 4'd1};

	assert property (@(posedge m1_start) $fell(m2_start) |-> !charReq)
		else noteFailure($sformatf("ERR charReq after reset %h, expected 0", $sampled(charReq)));
	assert property (@(posedge m1_start) disable iff (m2_start)
			charReq && $past(charReq) |-> $stable(charOut))
		else noteFailure($sformatf("ERR charOut %h changed under charReq", $sampled(charOut)));
	assert property (@(posedge m1_start) disable iff (m2_start) $fell(charReq) |-> $past(charAck))
		else noteFailure("charReq dropped before charAck was raised");
	assert property (@(posedge m1_start) disable iff (m2_start)
			$rose(charReq) |-> !charAck && !$past(charAck))
		else noteFailure("charReq rose while charAck was still high");
	assert property (@(posedge m1_start) disable iff (m2_start) reqRise |-> charOut.pos == expPos)
		else noteFailure($sformatf("ERR charOut.pos %h, expected %h",
			$sampled(charOut.pos), $sampled(expPos)));
	assert property (@(posedge m1_start) disable iff (m2_start)
			charReq |-> charOut.code == expectedCode(curFrame, charOut.pos))
		else noteFailure($sformatf("ERR charOut.code %h, expected %h", $sampled(charOut.code),
			expectedCode($sampled(curFrame), $sampled(charOut.pos))));

endmodule

bind lcdMonitorTop lcdMonitor_chk uChk (.*);

//--- sim/tbLcdMonitor.sv
module tbLcdMonitor;

	localparam int FrameChars = displayPkg::LineCount * displayPkg::ColumnCount;
	localparam int WatchdogCycles = 40 * FrameChars * 12; // 40 frames of slow characters

	logic m1_start = 1'b0;
	logic m2_start = 1'b1;
	monitorPkg::configStateT configState = monitorPkg::cfgIdle;
	logic modeSwitch = 1'b0;
	logic bus1Start = 1'b0;
	logic bus2Start = 1'b0;
	monitorPkg::busWordT bus1 = '0;
	monitorPkg::busWordT bus2 = '0;
	logic charReq;
	logic charAck = 1'b0;
	displayPkg::lcdCharT charOut;
	int unsigned ackDelay;

	lcdMonitorTop u_dut (.*);

	always #5 m1_start = ~m1_start;

	// a frame ends when line 1 col 15 is accepted
	task automatic waitFrames(input int count);
		repeat (count)
		begin
			@(posedge m1_start);
			while (!(charReq && charAck && charOut.pos == '1))
				@(posedge m1_start);
		end
	endtask

	task automatic holdConfigStep(input int step);
		@(posedge m1_start);
		modeSwitch <= 1'b0;
		configState <= monitorPkg::configStateT'(step);
		waitFrames(3);
	endtask

	task automatic showBusTraffic(input logic from1, input logic from2);
		@(posedge m1_start);
		modeSwitch <= 1'b1;
		bus1 <= $urandom;
		bus2 <= $urandom;
		bus1Start <= from1;
		bus2Start <= from2;
		@(posedge m1_start);
		bus1Start <= 1'b0;
		bus2Start <= 1'b0;
		waitFrames(3);
	endtask

	// panel driver, acks each request after 0 to 3 cycles
	always @(posedge m1_start)
	begin
		if (!m2_start && charReq && !charAck)
		begin
			ackDelay = $urandom % 4;
			repeat (ackDelay) @(posedge m1_start);
			charAck <= 1'b1;
		end
		else if (!charReq && charAck)
			charAck <= 1'b0;
	end

	always @(u_dut.uChk.errorCount)
	begin
		if (u_dut.uChk.errorCount != 0)
		begin
			$display("Simulation failed");
			$fatal(1, "stopped at the first checker error");
		end
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge m1_start);
		$display("Simulation failed");
		$fatal(1, "watchdog timeout, display frames stopped completing");
	end

	initial
	begin
		void'($urandom(32'hf9e2_8a51)); // seeds the random stream
		repeat (8) @(posedge m1_start);
		m2_start <= 1'b0;
		for (int step = 0; step <= 6; step++)
			holdConfigStep(step); // ends on the save step
		holdConfigStep(0); // done screen
		showBusTraffic(1'b1, 1'b0);
		showBusTraffic(1'b0, 1'b1);
		showBusTraffic(1'b1, 1'b1); // both strobes at once
		holdConfigStep(0); // monitor visit cleared the done flag
		if (u_dut.uChk.errorCount == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("Simulation failed");
			$fatal(1, "checker reported errors");
		end
	end

endmodule

//--- src/charStreamer.sv
module charStreamer (
	input logic m1_start,
	input logic m2_start,
	input monitorPkg::screenT screen,
	input monitorPkg::busWordT captured,
	output monitorPkg::frameStateT frame,
	output displayPkg::charPosT pos,
	input displayPkg::charCodeT code,
	output logic charReq,
	input logic charAck,
	output displayPkg::lcdCharT charOut
);

	typedef enum logic [1:0] {
		stIdle, // out of reset, nothing sent yet
		stRequest, // charReq up or about to go up
		stRelease // waiting for the driver to drop charAck
	} streamStateT;

	streamStateT state;

	always_ff @(posedge m1_start or posedge m2_start)
	begin
		if (m2_start)
		begin
			state <= stIdle;
			charReq <= 1'b0;
			pos <= '0;
			frame <= '{screen: monitorPkg::startScreen, captured: '0};
		end
		else
		begin
			case (state)
				stIdle, stRelease:
				begin
					if (!charAck)
					begin
						if (pos == '0)
							frame <= '{screen: screen, captured: captured}; // new frame
						state <= stRequest;
					end
				end
				stRequest:
				begin
					if (!charReq)
						charReq <= 1'b1; // snapshot settled a cycle ago
					else if (charAck)
					begin
						charReq <= 1'b0;
						state <= stRelease;
						if (pos.col == displayPkg::colIdxT'(displayPkg::ColumnCount - 1))
						begin
							pos.col <= '0;
							pos.line <= pos.line + 1'b1; // wraps after the last line
						end
						else
							pos.col <= pos.col + 1'b1;
					end
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// pos and frame hold still while charReq is high
	assign charOut = '{pos: pos, code: code};

endmodule

//--- src/displayPkg.sv
package displayPkg;

	localparam int LineCount = 2; // panel lines
	localparam int ColumnCount = 16; // characters per line

	typedef logic [$clog2(LineCount)-1:0] lineIdxT;
	typedef logic [$clog2(ColumnCount)-1:0] colIdxT;
	typedef logic [7:0] charCodeT; // plain ascii

	// line in the upper bit, so a +1 on the whole struct walks the panel
	typedef struct packed {
		lineIdxT line;
		colIdxT col;
	} charPosT;

	typedef struct packed {
		charPosT pos;
		charCodeT code;
	} lcdCharT;

	localparam charCodeT CodeZero = 8'h30; // '0'
	localparam charCodeT CodeOne = 8'h31; // '1'
	localparam charCodeT CodeDash = 8'h2D; // '-'

endpackage

//--- src/lcdMonitorTop.sv
module lcdMonitorTop (
	input logic m1_start,
	input logic m2_start,
	input monitorPkg::configStateT configState,
	input logic modeSwitch,
	input logic bus1Start,
	input logic bus2Start,
	input monitorPkg::busWordT bus1,
	input monitorPkg::busWordT bus2,
	output logic charReq,
	input logic charAck,
	output displayPkg::lcdCharT charOut
);

	monitorPkg::screenT screen;
	monitorPkg::busWordT captured;
	monitorPkg::frameStateT frame; // snapshot held for one refresh
	displayPkg::charPosT pos;
	displayPkg::charCodeT code;

	monitorInput uMonitorInput (
		.m1_start(m1_start),
		.m2_start(m2_start),
		.configState(configState),
		.modeSwitch(modeSwitch),
		.bus1Start(bus1Start),
		.bus2Start(bus2Start),
		.bus1(bus1),
		.bus2(bus2),
		.screen(screen),
		.captured(captured)
	);

	screenComposer uScreenComposer (
		.frame(frame),
		.pos(pos),
		.code(code)
	);

	charStreamer uCharStreamer (
		.m1_start(m1_start),
		.m2_start(m2_start),
		.screen(screen),
		.captured(captured),
		.frame(frame),
		.pos(pos),
		.code(code),
		.charReq(charReq),
		.charAck(charAck),
		.charOut(charOut)
	);

endmodule

//--- src/monitorInput.sv
module monitorInput (
	input logic m1_start,
	input logic m2_start,
	input monitorPkg::configStateT configState,
	input logic modeSwitch, // 0 config, 1 monitor
	input logic bus1Start,
	input logic bus2Start,
	input monitorPkg::busWordT bus1,
	input monitorPkg::busWordT bus2,
	output monitorPkg::screenT screen,
	output monitorPkg::busWordT captured
);

	logic configDone; // a save was seen since the last monitor visit
	monitorPkg::screenT nextScreen;

	// done memory
	always_ff @(posedge m1_start or posedge m2_start)
	begin
		if (m2_start)
			configDone <= 1'b0;
		else if (modeSwitch)
			configDone <= 1'b0; // monitor visit forgets the save
		else if (configState == monitorPkg::cfgSave)
			configDone <= 1'b1;
	end

	always_comb
	begin
		if (modeSwitch)
			nextScreen = monitorPkg::monitorScreen;
		else
		begin
			case (configState)
				monitorPkg::cfgIdle:
					nextScreen = configDone ? monitorPkg::doneScreen : monitorPkg::startScreen;
				monitorPkg::cfgMaster:
					nextScreen = monitorPkg::selectMaster;
				monitorPkg::cfgSlave:
					nextScreen = monitorPkg::selectSlave;
				monitorPkg::cfgAddress:
					nextScreen = monitorPkg::inputAddress;
				monitorPkg::cfgData:
					nextScreen = monitorPkg::inputData;
				monitorPkg::cfgBursts:
					nextScreen = monitorPkg::inputBursts;
				monitorPkg::cfgSave:
					nextScreen = monitorPkg::saveConfig;
				default:
					nextScreen = monitorPkg::startScreen; // steps 7 to 15 are unused
			endcase
		end
	end

	always_ff @(posedge m1_start or posedge m2_start)
	begin
		if (m2_start)
			screen <= monitorPkg::startScreen;
		else
			screen <= nextScreen;
	end

	// last bus transaction, master 1 first
	always_ff @(posedge m1_start or posedge m2_start)
	begin
		if (m2_start)
			captured <= '0;
		else if (bus1Start)
			captured <= bus1;
		else if (bus2Start)
			captured <= bus2;
	end

endmodule

//--- src/monitorPkg.sv
package monitorPkg;

	localparam int WordWidth = 16; // bus address and data width
	localparam int ShownBits = 14; // only 14 digit columns after the tag

	typedef struct packed {
		logic [WordWidth-1:0] address;
		logic [WordWidth-1:0] data;
	} busWordT;

	// step reported by the menu controller
	typedef enum logic [3:0] {
		cfgIdle = 4'd0,
		cfgMaster = 4'd1,
		cfgSlave = 4'd2,
		cfgAddress = 4'd3,
		cfgData = 4'd4,
		cfgBursts = 4'd5,
		cfgSave = 4'd6
	} configStateT;

	typedef enum logic [3:0] {
		startScreen,
		selectMaster,
		selectSlave,
		inputAddress,
		inputData,
		inputBursts,
		saveConfig,
		monitorScreen,
		doneScreen
	} screenT;

	// everything one frame is drawn from
	typedef struct packed {
		screenT screen;
		busWordT captured;
	} frameStateT;

	localparam displayPkg::charCodeT AddressTag = 8'h41; // 'A'
	localparam displayPkg::charCodeT DataTag = 8'h44; // 'D'

endpackage

//--- src/screenComposer.sv
module screenComposer (
	input monitorPkg::frameStateT frame,
	input displayPkg::charPosT pos,
	output displayPkg::charCodeT code
);

	`include "screenText.svh"

	logic [monitorPkg::WordWidth-1:0] word; // address on line 0, data on line 1
	logic [monitorPkg::ShownBits-1:0] shown;
	displayPkg::charCodeT tag;
	displayPkg::colIdxT bitSel;

	assign word = (pos.line == 1'b1) ? frame.captured.data : frame.captured.address;
	assign shown = word[monitorPkg::ShownBits-1:0]; // top two bits have no column
	assign tag = (pos.line == 1'b1) ? monitorPkg::DataTag : monitorPkg::AddressTag;

	// column 2 carries bit 13, column 15 bit 0
	assign bitSel = displayPkg::colIdxT'(monitorPkg::ShownBits + 1) - pos.col;

	always_comb
	begin
		if (frame.screen != monitorPkg::monitorScreen)
			code = screenChar(frame.screen, pos.line, pos.col);
		else if (pos.col == displayPkg::colIdxT'(0))
			code = tag;
		else if (pos.col == displayPkg::colIdxT'(1))
			code = displayPkg::CodeDash;
		else if (shown[bitSel])
			code = displayPkg::CodeOne;
		else
			code = displayPkg::CodeZero;
	end

endmodule
